// ==== rtl/ctrl_pkg.sv ====
// shared types of the core controller
// FSM state, PC source select toward fetch and the decode event code

package ctrl_pkg;

  //////////////////////////////////////////////////
  // controller FSM
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH
  } ctrl_state_e;

  // PC source for the fetch stage
  // codes 1, 3, 6 and 7 are left free for other fetch sources
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd2,
    PC_EXCEPTION = 3'd4,
    PC_ERET      = 3'd5
  } pc_mux_e;

  // winning request in the decode stage
  typedef enum logic [2:0] {
    EV_NONE,
    EV_BRANCH,
    EV_JUMP,
    EV_INT,
    EV_MRET,
    EV_EXT,
    EV_FLUSH
  } dec_event_e;

endpackage

// ==== rtl/perf_pkg.sv ====
// performance counter definitions
// event indices and the APB register map of the counter block

package perf_pkg;

  // number of counted core events
  localparam int PERF_NUM = 4;

  // bit position of each strobe in the event vector
  typedef enum logic [1:0] {
    PERF_JUMP,
    PERF_JR_STALL,
    PERF_BR_STALL,
    PERF_LD_STALL
  } perf_idx_e;

  //////////////////////////////////////////////////
  // APB register map
  //////////////////////////////////////////////////

  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // counters sit one word apart starting at the base
  localparam logic [APB_ADDR_W-1:0] REG_CNT_BASE   = 8'h00;
  localparam int                    REG_CNT_STRIDE = 4;
  // write bit 0 to clear all counters
  localparam logic [APB_ADDR_W-1:0] REG_CLEAR      = 8'h10;

endpackage

// ==== rtl/ctrl_event_arbiter.sv ====
// decode stage request arbiter of the controller
// reduces the raw requests to one event code by fixed priority

module ctrl_event_arbiter (
  input  logic                  instr_valid_i,
  input  logic                  branch_set_i,
  input  logic                  jump_set_i,
  input  logic                  int_req_i,
  input  logic                  mret_insn_i,
  input  logic                  ext_req_i,
  input  logic                  instr_multicycle_i,
  input  logic                  branch_in_id_i,
  input  logic                  pipe_flush_i,
  output ctrl_pkg::dec_event_e  dec_event_o,
  output logic                  exc_pending_o,
  output logic                  exc_is_ext_o
);

  import ctrl_pkg::*;

  // external interrupt may only be taken between instructions
  logic ext_allowed;

  // no irq while a multicycle op or a branch occupies decode
  assign ext_allowed = ext_req_i & ~instr_multicycle_i & ~branch_in_id_i;

  always_comb begin
    dec_event_o = EV_NONE;
    if (instr_valid_i) begin
      // highest priority first
      if (branch_set_i) begin
        dec_event_o = EV_BRANCH;
      end else if (jump_set_i) begin
        dec_event_o = EV_JUMP;
      end else if (int_req_i) begin
        dec_event_o = EV_INT;
      end else if (mret_insn_i) begin
        dec_event_o = EV_MRET;
      end else if (ext_allowed) begin
        dec_event_o = EV_EXT;
      end else if (pipe_flush_i) begin
        // wfi style flush
        dec_event_o = EV_FLUSH;
      end
    end else if (ext_req_i) begin
      // empty decode stage so irq is taken without gating
      dec_event_o = EV_EXT;
    end
  end

  // pending exception as seen outside the decode stage
  assign exc_pending_o = int_req_i | ext_req_i;
  assign exc_is_ext_o  = ext_req_i;

endmodule

// ==== rtl/ctrl_fsm.sv ====
// main controller FSM of the two stage core
// drives PC select, exception handshakes, stalls and write enable gating

module ctrl_fsm (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fetch_enable_i,
  input  logic                  id_ready_i,
  input  logic                  instr_valid_i,
  input  logic                  illegal_insn_i,
  input  ctrl_pkg::dec_event_e  dec_event_i,
  input  logic                  exc_pending_i,
  input  logic                  exc_is_ext_i,
  output logic                  instr_req_o,
  output logic                  ctrl_busy_o,
  output logic                  is_decoding_o,
  output logic                  deassert_we_o,
  output logic                  pc_set_o,
  output ctrl_pkg::pc_mux_e     pc_mux_o,
  output logic                  exc_ack_o,
  output logic                  irq_ack_o,
  output logic                  exc_save_if_o,
  output logic                  exc_save_id_o,
  output logic                  exc_restore_id_o,
  output logic                  halt_if_o,
  output logic                  halt_id_o
);

  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  //////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////

  always_comb begin
    // defaults for a running core
    state_d          = state_q;
    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    is_decoding_o    = 1'b0;
    pc_set_o         = 1'b0;
    pc_mux_o         = PC_BOOT;
    exc_ack_o        = 1'b0;
    irq_ack_o        = 1'b0;
    exc_save_if_o    = 1'b0;
    exc_save_id_o    = 1'b0;
    exc_restore_id_o = 1'b0;
    halt_if_o        = 1'b0;
    halt_id_o        = 1'b0;

    case (state_q)
      RESET: begin
        // idle until fetch is enabled
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      BOOT_SET: begin
        // load boot address into fetch
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        // wake on fetch enable or any interrupt
        if (fetch_enable_i || exc_pending_i) begin
          state_d = FIRST_FETCH;
        end
      end

      FIRST_FETCH: begin
        // wait for the first instruction to reach decode
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // interrupt that woke us is taken here
        if (exc_pending_i) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          irq_ack_o     = exc_is_ext_i;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE: begin
        is_decoding_o = instr_valid_i;
        case (dec_event_i)
          EV_BRANCH, EV_JUMP: begin
            pc_set_o = 1'b1;
            pc_mux_o = PC_JUMP;
          end
          EV_INT: begin
            // synchronous exception saves the pc of decode
            pc_set_o      = 1'b1;
            pc_mux_o      = PC_EXCEPTION;
            exc_ack_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end
          EV_MRET: begin
            pc_set_o         = 1'b1;
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
            // return into sleep when fetch is disabled
            if (!fetch_enable_i) begin
              halt_if_o = 1'b1;
              halt_id_o = 1'b1;
              state_d   = FLUSH;
            end
          end
          EV_EXT: begin
            // external irq saves the pc of fetch
            pc_set_o      = 1'b1;
            pc_mux_o      = PC_EXCEPTION;
            exc_ack_o     = 1'b1;
            irq_ack_o     = 1'b1;
            exc_save_if_o = 1'b1;
          end
          EV_FLUSH: begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH;
          end
          default: begin
            // plain instruction flows through
          end
        endcase
      end

      FLUSH: begin
        // single bubble then resume or sleep
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        state_d   = fetch_enable_i ? DECODE : SLEEP;
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  // register file write is blocked unless a legal instruction decodes
  assign deassert_we_o = ~is_decoding_o | illegal_insn_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== rtl/perf_counters.sv ====
// wrapping counters for the core performance events
// one counter per strobe with a shared synchronous clear

module perf_counters #(
  parameter int CNT_WIDTH = 16
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [perf_pkg::PERF_NUM-1:0]                 event_i,
  input  logic                                          clear_i,
  output logic [perf_pkg::PERF_NUM-1:0][CNT_WIDTH-1:0]  cnt_o
);

  import perf_pkg::*;

  logic [PERF_NUM-1:0][CNT_WIDTH-1:0] cnt_q;

  //////////////////////////////////////////////////
  // event counters
  //////////////////////////////////////////////////

  for (genvar g = 0; g < PERF_NUM; g++) begin : g_cnt
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        cnt_q[g] <= '0;
      end else if (clear_i) begin
        // clear has priority over a strobe in the same cycle
        cnt_q[g] <= '0;
      end else if (event_i[g]) begin
        // wraps at the counter width
        cnt_q[g] <= cnt_q[g] + 1'b1;
      end
    end
  end

  // values go straight to the register block
  assign cnt_o = cnt_q;

endmodule

// ==== rtl/perf_apb_regs.sv ====
// APB slave for the performance counters
// read counter words and write the clear command, no wait states

module perf_apb_regs #(
  parameter int CNT_WIDTH = 16
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          psel_i,
  input  logic                                          penable_i,
  input  logic                                          pwrite_i,
  input  logic [perf_pkg::APB_ADDR_W-1:0]               paddr_i,
  input  logic [perf_pkg::APB_DATA_W-1:0]               pwdata_i,
  input  logic [perf_pkg::PERF_NUM-1:0][CNT_WIDTH-1:0]  cnt_i,
  output logic [perf_pkg::APB_DATA_W-1:0]               prdata_o,
  output logic                                          pready_o,
  output logic                                          pslverr_o,
  output logic                                          clear_o
);

  import perf_pkg::*;

  logic                  setup;
  logic                  access;
  logic [APB_ADDR_W-1:0] cnt_off;
  logic                  cnt_hit;
  logic                  clr_hit;
  perf_idx_e             cnt_sel;
  logic [APB_DATA_W-1:0] rd_data;
  logic [APB_DATA_W-1:0] rdata_q;

  assign setup  = psel_i & ~penable_i;
  assign access = psel_i & penable_i;

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  // offset wraps high for addresses below the base
  assign cnt_off = paddr_i - REG_CNT_BASE;
  assign cnt_hit = (cnt_off < APB_ADDR_W'(REG_CNT_STRIDE * PERF_NUM)) &&
                   (cnt_off[1:0] == 2'b00);
  assign clr_hit = (paddr_i == REG_CLEAR);
  assign cnt_sel = perf_idx_e'(cnt_off[3:2]);

  // zero extended counter word, clear register reads as zero
  assign rd_data = cnt_hit ? APB_DATA_W'(cnt_i[cnt_sel]) : '0;

  // read data is sampled during setup and shown in the access phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (setup && !pwrite_i) begin
      rdata_q <= rd_data;
    end
  end

  assign prdata_o  = (access && !pwrite_i) ? rdata_q : '0;
  assign pready_o  = access;
  assign pslverr_o = access & ~(cnt_hit | clr_hit);
  // counters clear on the edge that ends the access phase
  assign clear_o   = access & pwrite_i & clr_hit & pwdata_i[0];

endmodule

// ==== rtl/ctrl_top.sv ====
// top of the core controller with its performance counters
// the core drives the decode requests and strobes, software reads over APB

module ctrl_top #(
  parameter int CNT_WIDTH = 16
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             fetch_enable_i,
  input  logic                             instr_valid_i,
  input  logic                             illegal_insn_i,
  input  logic                             mret_insn_i,
  input  logic                             pipe_flush_i,
  input  logic                             branch_set_i,
  input  logic                             jump_set_i,
  input  logic                             branch_in_id_i,
  input  logic                             instr_multicycle_i,
  input  logic                             int_req_i,
  input  logic                             ext_req_i,
  input  logic                             id_ready_i,
  // performance strobes
  input  logic                             jump_in_id_i,
  input  logic                             jump_stall_i,
  input  logic                             branch_stall_i,
  input  logic                             load_stall_i,
  // APB
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [perf_pkg::APB_ADDR_W-1:0]  paddr_i,
  input  logic [perf_pkg::APB_DATA_W-1:0]  pwdata_i,
  output logic [perf_pkg::APB_DATA_W-1:0]  prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  // controller outputs
  output logic                             instr_req_o,
  output logic                             ctrl_busy_o,
  output logic                             is_decoding_o,
  output logic                             deassert_we_o,
  output logic                             pc_set_o,
  output ctrl_pkg::pc_mux_e                pc_mux_o,
  output logic                             exc_ack_o,
  output logic                             irq_ack_o,
  output logic                             exc_save_if_o,
  output logic                             exc_save_id_o,
  output logic                             exc_restore_id_o,
  output logic                             halt_if_o,
  output logic                             halt_id_o
);

  import ctrl_pkg::*;
  import perf_pkg::*;

  dec_event_e                         dec_event;
  logic                               exc_pending;
  logic                               exc_is_ext;
  logic [PERF_NUM-1:0]                perf_event;
  logic [PERF_NUM-1:0][CNT_WIDTH-1:0] perf_cnt;
  logic                               perf_clear;

  //////////////////////////////////////////////////
  // controller
  //////////////////////////////////////////////////

  ctrl_event_arbiter arbiter_i (
    .instr_valid_i      (instr_valid_i),
    .branch_set_i       (branch_set_i),
    .jump_set_i         (jump_set_i),
    .int_req_i          (int_req_i),
    .mret_insn_i        (mret_insn_i),
    .ext_req_i          (ext_req_i),
    .instr_multicycle_i (instr_multicycle_i),
    .branch_in_id_i     (branch_in_id_i),
    .pipe_flush_i       (pipe_flush_i),
    .dec_event_o        (dec_event),
    .exc_pending_o      (exc_pending),
    .exc_is_ext_o       (exc_is_ext)
  );

  ctrl_fsm fsm_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch_enable_i   (fetch_enable_i),
    .id_ready_i       (id_ready_i),
    .instr_valid_i    (instr_valid_i),
    .illegal_insn_i   (illegal_insn_i),
    .dec_event_i      (dec_event),
    .exc_pending_i    (exc_pending),
    .exc_is_ext_i     (exc_is_ext),
    .instr_req_o      (instr_req_o),
    .ctrl_busy_o      (ctrl_busy_o),
    .is_decoding_o    (is_decoding_o),
    .deassert_we_o    (deassert_we_o),
    .pc_set_o         (pc_set_o),
    .pc_mux_o         (pc_mux_o),
    .exc_ack_o        (exc_ack_o),
    .irq_ack_o        (irq_ack_o),
    .exc_save_if_o    (exc_save_if_o),
    .exc_save_id_o    (exc_save_id_o),
    .exc_restore_id_o (exc_restore_id_o),
    .halt_if_o        (halt_if_o),
    .halt_id_o        (halt_id_o)
  );

  //////////////////////////////////////////////////
  // performance counters
  //////////////////////////////////////////////////

  // strobes placed by event index
  assign perf_event[PERF_JUMP]     = jump_in_id_i;
  assign perf_event[PERF_JR_STALL] = jump_stall_i;
  assign perf_event[PERF_BR_STALL] = branch_stall_i;
  assign perf_event[PERF_LD_STALL] = load_stall_i;

  perf_counters #(
    .CNT_WIDTH (CNT_WIDTH)
  ) counters_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .event_i (perf_event),
    .clear_i (perf_clear),
    .cnt_o   (perf_cnt)
  );

  perf_apb_regs #(
    .CNT_WIDTH (CNT_WIDTH)
  ) apb_regs_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .cnt_i     (perf_cnt),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .clear_o   (perf_clear)
  );

endmodule

// ==== verif/ctrl_model.svh ====
// reference model of the controller FSM and the performance counters
// included inside the testbench module body, reads the stimulus signals there

`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

  // model state codes, independent of the RTL encoding
  localparam int M_RESET = 0;
  localparam int M_BOOT  = 1;
  localparam int M_SLEEP = 2;
  localparam int M_FF    = 3;
  localparam int M_DEC   = 4;
  localparam int M_FLUSH = 5;

  // decode events in priority order
  localparam int E_NONE   = 0;
  localparam int E_BRANCH = 1;
  localparam int E_JUMP   = 2;
  localparam int E_INT    = 3;
  localparam int E_MRET   = 4;
  localparam int E_EXT    = 5;
  localparam int E_FLUSH  = 6;

  localparam int unsigned CNT_MASK = (1 << CNT_W) - 1;

  int          m_state = M_RESET;
  int          m_next;
  int unsigned m_cnt [4];

  // predicted controller outputs for the current cycle
  logic       exp_req;
  logic       exp_busy;
  logic       exp_decoding;
  logic       exp_we;
  logic       exp_pc_set;
  logic [2:0] exp_pc_mux;
  logic       exp_exc_ack;
  logic       exp_irq_ack;
  logic       exp_save_if;
  logic       exp_save_id;
  logic       exp_restore;
  logic       exp_halt;

  // decode stage priority, irq gated by multicycle ops and branches
  function automatic int model_event();
    logic ext_ok;
    ext_ok = ext_req && !instr_multicycle && !branch_in_id;
    if (!instr_valid) return ext_req ? E_EXT : E_NONE;
    if (branch_set) return E_BRANCH;
    if (jump_set) return E_JUMP;
    if (int_req) return E_INT;
    if (mret_insn) return E_MRET;
    if (ext_ok) return E_EXT;
    if (pipe_flush) return E_FLUSH;
    return E_NONE;
  endfunction

  function automatic void model_eval();
    int ev;
    ev           = model_event();
    m_next       = m_state;
    exp_req      = 1'b1;
    exp_busy     = 1'b1;
    exp_decoding = 1'b0;
    exp_pc_set   = 1'b0;
    exp_pc_mux   = PC_BOOT;
    exp_exc_ack  = 1'b0;
    exp_irq_ack  = 1'b0;
    exp_save_if  = 1'b0;
    exp_save_id  = 1'b0;
    exp_restore  = 1'b0;
    exp_halt     = 1'b0;
    case (m_state)
      M_RESET: begin
        exp_req  = 1'b0;
        exp_busy = 1'b0;
        if (fetch_enable) m_next = M_BOOT;
      end
      M_BOOT: begin
        exp_pc_set = 1'b1;
        m_next     = M_FF;
      end
      M_SLEEP: begin
        exp_req  = 1'b0;
        exp_busy = 1'b0;
        exp_halt = 1'b1;
        if (fetch_enable || int_req || ext_req) m_next = M_FF;
      end
      M_FF: begin
        if (id_ready) m_next = M_DEC;
        // pending exception is taken before the first decode
        if (int_req || ext_req) begin
          exp_pc_set  = 1'b1;
          exp_pc_mux  = PC_EXCEPTION;
          exp_exc_ack = 1'b1;
          exp_irq_ack = ext_req;
          exp_save_if = 1'b1;
        end
      end
      M_DEC: begin
        exp_decoding = instr_valid;
        if (ev == E_BRANCH || ev == E_JUMP) begin
          exp_pc_set = 1'b1;
          exp_pc_mux = PC_JUMP;
        end else if (ev == E_INT) begin
          exp_pc_set  = 1'b1;
          exp_pc_mux  = PC_EXCEPTION;
          exp_exc_ack = 1'b1;
          exp_save_id = 1'b1;
        end else if (ev == E_MRET) begin
          exp_pc_set  = 1'b1;
          exp_pc_mux  = PC_ERET;
          exp_restore = 1'b1;
          exp_halt    = !fetch_enable;
          if (!fetch_enable) m_next = M_FLUSH;
        end else if (ev == E_EXT) begin
          exp_pc_set  = 1'b1;
          exp_pc_mux  = PC_EXCEPTION;
          exp_exc_ack = 1'b1;
          exp_irq_ack = 1'b1;
          exp_save_if = 1'b1;
        end else if (ev == E_FLUSH) begin
          exp_halt = 1'b1;
          m_next   = M_FLUSH;
        end
      end
      default: begin
        // flush bubble
        exp_halt = 1'b1;
        m_next   = fetch_enable ? M_DEC : M_SLEEP;
      end
    endcase
    exp_we = !exp_decoding || illegal_insn;
  endfunction

  // clock edge: state update, counter increment or clear
  function automatic void model_step();
    if (!rst_n) begin
      m_state = M_RESET;
      foreach (m_cnt[i]) m_cnt[i] = 0;
    end else begin
      m_state = m_next;
      if (psel && penable && pwrite && paddr == 8'h10 && pwdata[0]) begin
        foreach (m_cnt[i]) m_cnt[i] = 0;
      end else begin
        foreach (m_cnt[i]) begin
          if (strobe[i]) m_cnt[i] = (m_cnt[i] + 1) & CNT_MASK;
        end
      end
    end
  endfunction

`endif

// ==== verif/tb_ctrl_top.sv ====
// testbench for the core controller and its APB performance counters
// random stimulus checked every cycle against the included model

module tb_ctrl_top;

  timeunit 1ns;
  timeprecision 100ps;

  import ctrl_pkg::*;

  // narrow counters so random runs wrap them
  localparam int CNT_W = 5;

  logic        clk;
  logic        rst_n;
  logic        fetch_enable;
  logic        instr_valid;
  logic        illegal_insn;
  logic        mret_insn;
  logic        pipe_flush;
  logic        branch_set;
  logic        jump_set;
  logic        branch_in_id;
  logic        instr_multicycle;
  logic        int_req;
  logic        ext_req;
  logic        id_ready;
  // strobes in event index order of jump, jr stall, branch stall and load stall
  logic [3:0]  strobe;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        instr_req;
  logic        ctrl_busy;
  logic        is_decoding;
  logic        deassert_we;
  logic        pc_set;
  pc_mux_e     pc_mux;
  logic        exc_ack;
  logic        irq_ack;
  logic        exc_save_if;
  logic        exc_save_id;
  logic        exc_restore_id;
  logic        halt_if;
  logic        halt_id;

  string test_name;
  int    test_errs;
  int    total_errs;
  int    n_checks;
  int    n_tests;
  int    n_failed;
  bit    aborted;

  `include "ctrl_model.svh"

  ctrl_top #(
    .CNT_WIDTH (CNT_W)
  ) dut_i (
    .clk (clk), .rst_n (rst_n), .fetch_enable_i (fetch_enable),
    .instr_valid_i (instr_valid), .illegal_insn_i (illegal_insn),
    .mret_insn_i (mret_insn), .pipe_flush_i (pipe_flush),
    .branch_set_i (branch_set), .jump_set_i (jump_set),
    .branch_in_id_i (branch_in_id), .instr_multicycle_i (instr_multicycle),
    .int_req_i (int_req), .ext_req_i (ext_req), .id_ready_i (id_ready),
    .jump_in_id_i (strobe[0]), .jump_stall_i (strobe[1]),
    .branch_stall_i (strobe[2]), .load_stall_i (strobe[3]),
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
    .paddr_i (paddr), .pwdata_i (pwdata), .prdata_o (prdata),
    .pready_o (pready), .pslverr_o (pslverr),
    .instr_req_o (instr_req), .ctrl_busy_o (ctrl_busy),
    .is_decoding_o (is_decoding), .deassert_we_o (deassert_we),
    .pc_set_o (pc_set), .pc_mux_o (pc_mux), .exc_ack_o (exc_ack),
    .irq_ack_o (irq_ack), .exc_save_if_o (exc_save_if),
    .exc_save_id_o (exc_save_id), .exc_restore_id_o (exc_restore_id),
    .halt_if_o (halt_if), .halt_id_o (halt_id)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // checking and cycle helpers
  //////////////////////////////////////////////////

  task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
    n_checks++;
    assert (exp === act) else begin
      $display("CHECK FAILED %s %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  // outputs are sampled late in the cycle where they are stable
  task automatic settle();
    #40;
    model_eval();
    check_val("instr_req_o", exp_req, instr_req);
    check_val("ctrl_busy_o", exp_busy, ctrl_busy);
    check_val("is_decoding_o", exp_decoding, is_decoding);
    check_val("deassert_we_o", exp_we, deassert_we);
    check_val("pc_set_o", exp_pc_set, pc_set);
    if (exp_pc_set) check_val("pc_mux_o", exp_pc_mux, pc_mux);
    check_val("exc_ack_o", exp_exc_ack, exc_ack);
    check_val("irq_ack_o", exp_irq_ack, irq_ack);
    check_val("exc_save_if_o", exp_save_if, exc_save_if);
    check_val("exc_save_id_o", exp_save_id, exc_save_id);
    check_val("exc_restore_id_o", exp_restore, exc_restore_id);
    check_val("halt_if_o", exp_halt, halt_if);
    check_val("halt_id_o", exp_halt, halt_id);
  endtask

  // new inputs go in 5 ns after the edge
  task automatic advance();
    model_step();
    @(posedge clk);
    #5;
  endtask

  task automatic tick();
    settle();
    advance();
  endtask

  task automatic drive_random(int fe_pct);
    fetch_enable     = ($urandom % 100) < fe_pct;
    instr_valid      = ($urandom % 4) != 0;
    illegal_insn     = ($urandom % 8) == 0;
    mret_insn        = ($urandom % 8) == 0;
    pipe_flush       = ($urandom % 10) == 0;
    branch_set       = ($urandom % 6) == 0;
    jump_set         = ($urandom % 6) == 0;
    branch_in_id     = ($urandom % 4) == 0;
    instr_multicycle = ($urandom % 4) == 0;
    int_req          = ($urandom % 10) == 0;
    ext_req          = ($urandom % 6) == 0;
    id_ready         = 1'($urandom % 2);
    strobe           = 4'($urandom);
  endtask

  // no decode requests beyond fetch enable and rare exceptions
  task automatic drive_quiet(int fe_pct, int exc_pct);
    drive_random(fe_pct);
    instr_valid  = 1'b1;
    illegal_insn = 1'b0;
    mret_insn    = 1'b0;
    pipe_flush   = 1'b0;
    branch_set   = 1'b0;
    jump_set     = 1'b0;
    int_req      = ($urandom % 100) < exc_pct;
    ext_req      = ($urandom % 100) < exc_pct;
  endtask

  // bounded wait for the FSM to reach a state
  task automatic wait_state(int target, int fe_pct, int exc_pct, int limit, string what);
    int n;
    n = 0;
    while (m_state != target && n < limit) begin
      drive_quiet(fe_pct, exc_pct);
      tick();
      n++;
    end
    if (m_state != target) begin
      $display("ERROR in %s: %s not reached within %0d cycles", test_name, what, limit);
      test_errs++;
      aborted = 1'b1;
    end
  endtask

  // one APB transfer of setup then access with strobes held off
  task automatic apb_access(logic wr, logic [7:0] addr, logic [31:0] wdata,
                            logic exp_err, logic [31:0] exp_rdata);
    strobe  = '0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    tick();
    penable = 1'b1;
    settle();
    check_val("pready_o", 1, pready);
    check_val("pslverr_o", exp_err, pslverr);
    if (!wr) check_val("prdata_o", exp_rdata, prdata);
    advance();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_counters();
    for (int i = 0; i < 4; i++) begin
      apb_access(1'b0, 8'(4 * i), 0, 1'b0, m_cnt[i]);
    end
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    n_tests++;
    total_errs += test_errs;
    if (test_errs != 0) n_failed++;
    $display("test %s: %s, %0d errors", test_name, test_errs == 0 ? "ok" : "FAIL", test_errs);
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic reset_boot();
    start_test("reset_boot");
    // fetch enable during reset must not start the core
    repeat (5) begin
      drive_random(100);
      tick();
    end
    rst_n = 1'b1;
    repeat (3) begin
      drive_quiet(0, 0);
      tick();
    end
    drive_quiet(100, 0);
    tick();
    // boot cycle then first fetch
    drive_quiet(100, 0);
    tick();
    wait_state(M_DEC, 100, 0, 40, "DECODE after boot");
    end_test();
  endtask

  task automatic decode_priority();
    start_test("decode_priority");
    repeat (300) begin
      drive_random(90);
      tick();
    end
    end_test();
  endtask

  task automatic flush_sleep_wake();
    start_test("flush_sleep_wake");
    for (int k = 0; k < 6 && !aborted; k++) begin
      wait_state(M_DEC, 100, 0, 40, "DECODE");
      // alternate a wfi flush and an mret with fetch disabled
      drive_quiet(0, 0);
      if (k % 2 == 0) pipe_flush = 1'b1;
      else mret_insn = 1'b1;
      tick();
      wait_state(M_SLEEP, 0, 0, 4, "SLEEP through FLUSH");
      repeat (3) begin
        drive_quiet(0, 0);
        tick();
      end
      wait_state(M_FF, 10, 10, 60, "wake into FIRST_FETCH");
      wait_state(M_DEC, 100, 30, 40, "DECODE after wake");
    end
    end_test();
  endtask

  task automatic write_enable();
    start_test("write_enable");
    repeat (200) begin
      drive_random(70);
      illegal_insn = 1'($urandom % 2);
      tick();
    end
    end_test();
  endtask

  task automatic counters_apb();
    start_test("counters_apb");
    drive_quiet(100, 0);
    read_counters();
    repeat (120) begin
      drive_random(90);
      tick();
    end
    drive_quiet(100, 0);
    read_counters();
    end_test();
  endtask

  task automatic clear_bad_addr();
    start_test("clear_bad_addr");
    drive_quiet(100, 0);
    apb_access(1'b1, 8'h10, 32'h1, 1'b0, 0);
    read_counters();
    repeat (40) begin
      drive_random(90);
      tick();
    end
    // bit 0 low leaves the counters alone
    apb_access(1'b1, 8'h10, 32'h2, 1'b0, 0);
    apb_access(1'b0, 8'h10, 0, 1'b0, 0);
    apb_access(1'b0, 8'h14, 0, 1'b1, 0);
    apb_access(1'b0, 8'h06, 0, 1'b1, 0);
    apb_access(1'b1, 8'h40, 32'h1, 1'b1, 0);
    apb_access(1'b1, 8'hfc, 32'h1, 1'b1, 0);
    read_counters();
    end_test();
  endtask

  initial begin
    void'($urandom(26));
    clk     = 1'b0;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    drive_quiet(0, 0);
    strobe  = '0;
    @(posedge clk);
    #5;
    reset_boot();
    if (!aborted) decode_priority();
    if (!aborted) flush_sleep_wake();
    if (!aborted) write_enable();
    if (!aborted) counters_apb();
    if (!aborted) clear_bad_addr();
    $display("tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
             n_tests, n_failed, n_checks, total_errs);
    if (aborted || total_errs != 0) begin
      $display("Testbench failed");
    end else begin
      $display("Testbench passed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+verif
rtl/ctrl_pkg.sv
rtl/perf_pkg.sv
rtl/ctrl_event_arbiter.sv
rtl/ctrl_fsm.sv
rtl/perf_counters.sv
rtl/perf_apb_regs.sv
rtl/ctrl_top.sv
verif/tb_ctrl_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the controller testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f sources.f --top-module tb_ctrl_top \
  -o tb_ctrl_top || exit 1
out=$(./obj_dir/tb_ctrl_top)
echo "$out"
echo "$out" | grep -qx "Testbench passed" && exit 0 || exit 1
